// ==== include/bp_cfg.svh ====
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// ********************
// Global history
// ********************
`define GHIST_SIZE          64
`define GHIST_WIDTH         6
`define SLOT_NUM            2

// ********************
// TAGE folding
// ********************
`define TAGE_BANK           4
`define TAGE_SET_WIDTH      8
`define TAGE_TAG_COMPRESS1  8
`define TAGE_TAG_COMPRESS2  7

// History length per bank, shortest first
`define TAGE_HIST_LEN0      8
`define TAGE_HIST_LEN1      13
`define TAGE_HIST_LEN2      21
`define TAGE_HIST_LEN3      34

`endif

// ==== verilog/bp_hist_pkg.sv ====
`default_nettype none

`include "bp_cfg.svh"

package bp_hist_pkg;

    // ********************
    // Folded history
    // ********************

    // Three folds per bank, bank 0 in the low slice
    typedef struct packed {
        logic [`TAGE_BANK-1:0][`TAGE_SET_WIDTH-1:0]     fold_idx;
        logic [`TAGE_BANK-1:0][`TAGE_TAG_COMPRESS1-1:0] fold_tag1;
        logic [`TAGE_BANK-1:0][`TAGE_TAG_COMPRESS2-1:0] fold_tag2;
    } fold_hist_t;

    // ********************
    // Restore checkpoint
    // ********************

    // Position and folds as they were before the block
    typedef struct packed {
        logic [`GHIST_WIDTH-1:0] ghist_idx;
        fold_hist_t              folds;
    } hist_ckpt_t;

    // Width of one checkpoint
    localparam int HIST_CKPT_BITS = $bits(hist_ckpt_t);

endpackage

`default_nettype wire

// ==== verilog/bp_csr_pkg.sv ====
`default_nettype none

package bp_csr_pkg;

    // Word addresses on the Wishbone port
    typedef enum logic [7:0] {
        CSR_CTRL         = 8'h00,
        CSR_POS          = 8'h01,
        CSR_COUNT_REDIR  = 8'h02,
        CSR_COUNT_SQUASH = 8'h03,
        CSR_GHIST_LO     = 8'h04,
        CSR_GHIST_HI     = 8'h05,
        CSR_FOLD_BASE    = 8'h08   // + 4*bank + field
    } csr_addr_e;

    // CTRL bits
    localparam int CTRL_FREEZE_BIT = 0;
    localparam int CTRL_CLEAR_BIT  = 1;   // self clearing

    // Field offsets inside one bank's fold window
    localparam int FOLD_FIELD_IDX  = 0;
    localparam int FOLD_FIELD_TAG1 = 1;
    localparam int FOLD_FIELD_TAG2 = 2;

endpackage

`default_nettype wire

// ==== verilog/fold_history.sv ====
`default_nettype none
`timescale 1ns/1ps

module fold_history #(
    parameter int COMPRESS_LENGTH = 8,
    parameter int ORIGIN_LENGTH   = 10
) (
    input  logic [COMPRESS_LENGTH-1:0] origin,
    input  logic [1:0]                 cond_num,
    input  logic                       dir,
    input  logic [1:0]                 reverse_dir,   // [0] oldest leaving bit
    output logic [COMPRESS_LENGTH-1:0] out
);
    // Where bits of age L and L+1 land after the shift
    localparam int OUT_POINT0 = ORIGIN_LENGTH % COMPRESS_LENGTH;
    localparam int OUT_POINT1 = (ORIGIN_LENGTH + 1) % COMPRESS_LENGTH;

    logic [COMPRESS_LENGTH-1:0] rot1;
    logic [COMPRESS_LENGTH-1:0] rot2;
    logic [COMPRESS_LENGTH-1:0] new_bit;
    logic [COMPRESS_LENGTH-1:0] drop1;
    logic [COMPRESS_LENGTH-1:0] drop2;

    assign rot1    = {origin[COMPRESS_LENGTH-2:0], origin[COMPRESS_LENGTH-1]};
    assign rot2    = {origin[COMPRESS_LENGTH-3:0], origin[COMPRESS_LENGTH-1 -: 2]};
    assign new_bit = COMPRESS_LENGTH'(dir);   // Taken bit is always the newest
    assign drop1   = COMPRESS_LENGTH'(reverse_dir[0]) << OUT_POINT0;
    assign drop2   = (COMPRESS_LENGTH'(reverse_dir[1]) << OUT_POINT0)
                   ^ (COMPRESS_LENGTH'(reverse_dir[0]) << OUT_POINT1);

    always_comb begin
        case (cond_num)
            2'd1:    out = rot1 ^ new_bit ^ drop1;
            2'd2:    out = rot2 ^ new_bit ^ drop2;
            default: out = origin;   // Nothing pushed
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/history_control.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "bp_cfg.svh"

module history_control
    import bp_hist_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    result_en,
    input  logic [1:0]              result_cond_num,
    input  logic                    result_taken,
    input  logic                    s2_redirect,
    input  hist_ckpt_t              redir_ckpt,
    input  logic                    squash,
    input  hist_ckpt_t              squash_ckpt,
    input  logic [1:0]              squash_cond_num,
    input  logic                    squash_taken,
    input  logic                    freeze,
    input  logic                    clear,
    output logic [`GHIST_WIDTH-1:0] hist_idx,
    output fold_hist_t              hist_folds,
    output logic [`GHIST_WIDTH-1:0] pos,
    output logic [`GHIST_SIZE-1:0]  ghist,
    output logic                    redirect_pulse,
    output logic                    squash_pulse
);
    localparam int IW = `GHIST_WIDTH;
    localparam int HIST_LEN [`TAGE_BANK] = '{
        `TAGE_HIST_LEN0, `TAGE_HIST_LEN1, `TAGE_HIST_LEN2, `TAGE_HIST_LEN3
    };

    logic                            restore;
    logic [1:0]                      push_num;
    logic                            taken_sel;
    logic [IW-1:0]                   base_idx;
    fold_hist_t                      fold_base;
    fold_hist_t                      fold_next;
    logic                            fold_we;
    logic [`SLOT_NUM-1:0]            ghist_we;
    logic [`SLOT_NUM-1:0]            cond_result;
    logic [`SLOT_NUM-1:0][IW-1:0]    we_idx;

    // ********************
    // Source selection
    // ********************
    assign restore        = squash | s2_redirect;
    assign squash_pulse   = squash;
    assign redirect_pulse = s2_redirect & ~squash;   // Squash wins

    always_comb begin
        if (squash) begin
            push_num  = squash_cond_num;
            taken_sel = squash_taken;
            base_idx  = squash_ckpt.ghist_idx;
            fold_base = squash_ckpt.folds;
        end else if (s2_redirect) begin
            push_num  = result_en ? result_cond_num : 2'd0;
            taken_sel = result_taken;
            base_idx  = redir_ckpt.ghist_idx;
            fold_base = redir_ckpt.folds;
        end else begin
            push_num  = (result_en && !freeze) ? result_cond_num : 2'd0;
            taken_sel = result_taken;
            base_idx  = pos;
            fold_base = hist_folds;
        end
    end

    // Predictor indexes with the restored position right away
    assign hist_idx = restore ? base_idx + IW'(push_num) : pos;

    // Outcome bits: leading zeros, taken last
    assign ghist_we[0]    = |push_num;
    assign ghist_we[1]    = push_num[1];
    assign cond_result[0] = (push_num == 2'd1) ? taken_sel : 1'b0;
    assign cond_result[1] = taken_sel;
    assign we_idx[0]      = base_idx;
    assign we_idx[1]      = base_idx + IW'(1);
    assign fold_we        = (|ghist_we) | restore;

    // ********************
    // Fold update
    // ********************
    for (genvar b = 0; b < `TAGE_BANK; b++) begin : g_bank
        logic [IW-1:0]        old_idx;
        logic [`SLOT_NUM-1:0] reverse_dir;

        // Entries that fall out of this bank's window
        assign old_idx        = base_idx - IW'(HIST_LEN[b]);
        assign reverse_dir[0] = ghist[old_idx];
        assign reverse_dir[1] = ghist[old_idx + IW'(1)];

        fold_history #(
            .COMPRESS_LENGTH (`TAGE_SET_WIDTH),
            .ORIGIN_LENGTH   (HIST_LEN[b])
        ) fold_idx_i (
            .origin      (fold_base.fold_idx[b]),
            .cond_num    (push_num),
            .dir         (taken_sel),
            .reverse_dir (reverse_dir),
            .out         (fold_next.fold_idx[b])
        );

        fold_history #(
            .COMPRESS_LENGTH (`TAGE_TAG_COMPRESS1),
            .ORIGIN_LENGTH   (HIST_LEN[b])
        ) fold_tag1_i (
            .origin      (fold_base.fold_tag1[b]),
            .cond_num    (push_num),
            .dir         (taken_sel),
            .reverse_dir (reverse_dir),
            .out         (fold_next.fold_tag1[b])
        );

        fold_history #(
            .COMPRESS_LENGTH (`TAGE_TAG_COMPRESS2),
            .ORIGIN_LENGTH   (HIST_LEN[b])
        ) fold_tag2_i (
            .origin      (fold_base.fold_tag2[b]),
            .cond_num    (push_num),
            .dir         (taken_sel),
            .reverse_dir (reverse_dir),
            .out         (fold_next.fold_tag2[b])
        );
    end

    // ********************
    // State
    // ********************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos        <= '0;
            ghist      <= '0;
            hist_folds <= '0;
        end else if (clear) begin
            pos        <= '0;
            ghist      <= '0;
            hist_folds <= '0;
        end else begin
            pos <= base_idx + IW'(push_num);
            if (fold_we) begin
                hist_folds <= fold_next;
            end
            for (int s = 0; s < `SLOT_NUM; s++) begin
                if (ghist_we[s]) begin
                    ghist[we_idx[s]] <= cond_result[s];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hist_csr.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "bp_cfg.svh"

module hist_csr
    import bp_hist_pkg::*;
    import bp_csr_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [7:0]              wb_adr,
    input  logic [31:0]             wb_dat_w,
    output logic [31:0]             wb_dat_r,
    output logic                    wb_ack,
    input  logic [`GHIST_WIDTH-1:0] pos,
    input  logic [`GHIST_SIZE-1:0]  ghist,
    input  fold_hist_t              folds,
    input  logic                    redirect_pulse,
    input  logic                    squash_pulse,
    output logic                    freeze,
    output logic                    clear
);
    localparam int BANK_W = $clog2(`TAGE_BANK);

    logic              req;
    logic              wr_ctrl;
    logic [31:0]       rd_data;
    logic [7:0]        fold_off;
    logic [BANK_W-1:0] fold_bank;
    logic [31:0]       cnt_redir;
    logic [31:0]       cnt_squash;

    assign req       = wb_cyc & wb_stb & ~wb_ack;   // New cycle only
    assign wr_ctrl   = req & wb_we & (wb_adr == CSR_CTRL);
    assign fold_off  = wb_adr - CSR_FOLD_BASE;
    assign fold_bank = fold_off[2 +: BANK_W];

    // ********************
    // Control and counters
    // ********************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack     <= 1'b0;
            freeze     <= 1'b0;
            clear      <= 1'b0;
            cnt_redir  <= '0;
            cnt_squash <= '0;
        end else begin
            wb_ack <= req;
            clear  <= wr_ctrl & wb_dat_w[CTRL_CLEAR_BIT];   // One cycle pulse
            if (wr_ctrl) begin
                freeze <= wb_dat_w[CTRL_FREEZE_BIT];
            end
            if (clear) begin
                cnt_redir  <= '0;
                cnt_squash <= '0;
            end else begin
                if (redirect_pulse && cnt_redir != '1) cnt_redir <= cnt_redir + 32'd1;
                if (squash_pulse && cnt_squash != '1) cnt_squash <= cnt_squash + 32'd1;
            end
        end
    end

    // Read mux
    always_comb begin
        rd_data = '0;
        case (wb_adr)
            CSR_CTRL: begin
                rd_data[CTRL_FREEZE_BIT] = freeze;
                rd_data[CTRL_CLEAR_BIT]  = clear;
            end
            CSR_POS:          rd_data = 32'(pos);
            CSR_COUNT_REDIR:  rd_data = cnt_redir;
            CSR_COUNT_SQUASH: rd_data = cnt_squash;
            CSR_GHIST_LO:     rd_data = ghist[31:0];
            CSR_GHIST_HI:     rd_data = ghist[`GHIST_SIZE-1:32];
            default: begin
                if (fold_off < 8'(4 * `TAGE_BANK)) begin
                    case (int'(fold_off[1:0]))
                        FOLD_FIELD_IDX:  rd_data = 32'(folds.fold_idx[fold_bank]);
                        FOLD_FIELD_TAG1: rd_data = 32'(folds.fold_tag1[fold_bank]);
                        FOLD_FIELD_TAG2: rd_data = 32'(folds.fold_tag2[fold_bank]);
                        default:         rd_data = '0;
                    endcase
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (req && !wb_we) wb_dat_r <= rd_data;   // Valid with ack
    end

endmodule

`default_nettype wire

// ==== verilog/bp_history_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "bp_cfg.svh"

module bp_history_top
    import bp_hist_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    // Prediction side
    input  logic                    result_en,
    input  logic [1:0]              result_cond_num,
    input  logic                    result_taken,
    input  logic                    s2_redirect,
    input  hist_ckpt_t              redir_ckpt,
    input  logic                    squash,
    input  hist_ckpt_t              squash_ckpt,
    input  logic [1:0]              squash_cond_num,
    input  logic                    squash_taken,
    output logic [`GHIST_WIDTH-1:0] hist_idx,
    output fold_hist_t              hist_folds,
    // Wishbone
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [7:0]              wb_adr,
    input  logic [31:0]             wb_dat_w,
    output logic [31:0]             wb_dat_r,
    output logic                    wb_ack
);
    logic                    freeze;
    logic                    clear;
    logic [`GHIST_WIDTH-1:0] pos;
    logic [`GHIST_SIZE-1:0]  ghist;
    logic                    redirect_pulse;
    logic                    squash_pulse;

    history_control history_control_i (
        .clk             (clk),
        .rst             (rst),
        .result_en       (result_en),
        .result_cond_num (result_cond_num),
        .result_taken    (result_taken),
        .s2_redirect     (s2_redirect),
        .redir_ckpt      (redir_ckpt),
        .squash          (squash),
        .squash_ckpt     (squash_ckpt),
        .squash_cond_num (squash_cond_num),
        .squash_taken    (squash_taken),
        .freeze          (freeze),
        .clear           (clear),
        .hist_idx        (hist_idx),
        .hist_folds      (hist_folds),
        .pos             (pos),
        .ghist           (ghist),
        .redirect_pulse  (redirect_pulse),
        .squash_pulse    (squash_pulse)
    );

    hist_csr hist_csr_i (
        .clk            (clk),
        .rst            (rst),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .pos            (pos),
        .ghist          (ghist),
        .folds          (hist_folds),
        .redirect_pulse (redirect_pulse),
        .squash_pulse   (squash_pulse),
        .freeze         (freeze),
        .clear          (clear)
    );

endmodule

`default_nettype wire

// ==== dv/hist_tb_clk.sv ====
`default_nettype none
`timescale 1ns/1ps

module hist_tb_clk #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;   // Released just after an edge
    end

endmodule

`default_nettype wire

// ==== dv/hist_properties.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "bp_cfg.svh"

module hist_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    wb_cyc,
    input logic                    wb_stb,
    input logic                    wb_ack,
    input logic                    freeze,
    input logic                    clear,
    input logic                    squash,
    input logic                    s2_redirect,
    input logic [`GHIST_WIDTH-1:0] pos
);
    // ********************
    // Wishbone handshake
    // ********************
    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack held longer than one cycle");

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack rose without cyc and stb");

    // Frozen position only moves on a restore
    pos_frozen: assert property (@(posedge clk) disable iff (rst)
        freeze && !squash && !s2_redirect && !clear |=> pos == $past(pos))
        else $error("pos moved while frozen");

endmodule

bind bp_history_top hist_properties hist_properties_i (
    .clk         (clk),
    .rst         (rst),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .freeze      (freeze),
    .clear       (clear),
    .squash      (squash),
    .s2_redirect (s2_redirect),
    .pos         (pos)
);

`default_nettype wire

// ==== dv/hist_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "bp_cfg.svh"

module hist_tb
    import bp_hist_pkg::*;
    import bp_csr_pkg::*;
();
    localparam int N_PUSH      = 200;
    localparam int CYCLE_LIMIT = 2 * (N_PUSH + 100);   // Directed steps fit in 100 cycles
    localparam int HIST_LEN [`TAGE_BANK] = '{
        `TAGE_HIST_LEN0, `TAGE_HIST_LEN1, `TAGE_HIST_LEN2, `TAGE_HIST_LEN3
    };

    logic                    clk;
    logic                    rst;
    logic                    result_en;
    logic [1:0]              result_cond_num;
    logic                    result_taken;
    logic                    s2_redirect;
    hist_ckpt_t              redir_ckpt;
    logic                    squash;
    hist_ckpt_t              squash_ckpt;
    logic [1:0]              squash_cond_num;
    logic                    squash_taken;
    logic [`GHIST_WIDTH-1:0] hist_idx;
    fold_hist_t              hist_folds;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [7:0]              wb_adr;
    logic [31:0]             wb_dat_w;
    logic [31:0]             wb_dat_r;
    logic                    wb_ack;

    // Reference model state
    logic        hist_m [`GHIST_SIZE];
    int          pos_m;
    logic        frozen_m;
    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          exp_redir;
    int          exp_squash;
    int          cycle_cnt = 0;

    hist_tb_clk clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    bp_history_top dut_i (
        .clk             (clk),
        .rst             (rst),
        .result_en       (result_en),
        .result_cond_num (result_cond_num),
        .result_taken    (result_taken),
        .s2_redirect     (s2_redirect),
        .redir_ckpt      (redir_ckpt),
        .squash          (squash),
        .squash_ckpt     (squash_ckpt),
        .squash_cond_num (squash_cond_num),
        .squash_taken    (squash_taken),
        .hist_idx        (hist_idx),
        .hist_folds      (hist_folds),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_dat_w        (wb_dat_w),
        .wb_dat_r        (wb_dat_r),
        .wb_ack          (wb_ack)
    );

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, tests did not finish", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ********************
    // Model
    // ********************
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 16'hB400;
        return b;
    endfunction

    function automatic int rand_bits(input int k);
        int v;
        v = 0;
        for (int i = 0; i < k; i++) v = (v << 1) | int'(lfsr_bit());
        return v;
    endfunction

    // Zeros first, taken outcome last
    function automatic void model_push(input logic [1:0] n, input logic taken);
        if (n == 2'd1) begin
            hist_m[pos_m] = taken;
        end else if (n == 2'd2) begin
            hist_m[pos_m] = 1'b0;
            hist_m[(pos_m + 1) % `GHIST_SIZE] = taken;
        end
        pos_m = (pos_m + int'(n)) % `GHIST_SIZE;
    endfunction

    // Age a lands on bit a mod width
    function automatic logic [7:0] fold_of(input int len, input int width);
        logic [7:0] f;
        f = '0;
        for (int a = 0; a < len; a++) begin
            if (hist_m[(pos_m - 1 - a + `GHIST_SIZE) % `GHIST_SIZE]) f[a % width] = ~f[a % width];
        end
        return f;
    endfunction

    function automatic fold_hist_t model_folds();
        fold_hist_t m;
        m = '0;
        for (int b = 0; b < `TAGE_BANK; b++) begin
            m.fold_idx[b]  = fold_of(HIST_LEN[b], `TAGE_SET_WIDTH);
            m.fold_tag1[b] = fold_of(HIST_LEN[b], `TAGE_TAG_COMPRESS1);
            m.fold_tag2[b] = 7'(fold_of(HIST_LEN[b], `TAGE_TAG_COMPRESS2));
        end
        return m;
    endfunction

    function automatic logic [63:0] model_ghist();
        logic [63:0] v;
        for (int i = 0; i < `GHIST_SIZE; i++) v[i] = hist_m[i];
        return v;
    endfunction

    function automatic hist_ckpt_t take_ckpt();
        hist_ckpt_t ck;
        ck.ghist_idx = 6'(pos_m);
        ck.folds     = model_folds();
        return ck;
    endfunction

    // ********************
    // Drivers and checks
    // ********************
    task automatic check_hex(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_state(input int exp_idx);
        fold_hist_t exp_f;
        exp_f = model_folds();
        check_hex("hist_idx", 64'(exp_idx), 64'(hist_idx));
        for (int b = 0; b < `TAGE_BANK; b++) begin
            check_hex($sformatf("fold_idx[%0d]", b), 64'(exp_f.fold_idx[b]),
                      64'(hist_folds.fold_idx[b]));
            check_hex($sformatf("fold_tag1[%0d]", b), 64'(exp_f.fold_tag1[b]),
                      64'(hist_folds.fold_tag1[b]));
            check_hex($sformatf("fold_tag2[%0d]", b), 64'(exp_f.fold_tag2[b]),
                      64'(hist_folds.fold_tag2[b]));
        end
    endtask

    task automatic idle_check();
        @(negedge clk);
        check_state(pos_m);
        @(posedge clk);
        #1;
    endtask

    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        waited   = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_ack && waited < 8);
        if (!wb_ack) begin
            errors++;
            $display("No Wishbone ack for address %h", adr);
        end
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [7:0] adr, input logic [63:0] exp);
        logic [31:0] rd;
        wb_access(1'b0, adr, 32'd0, rd);
        check_hex(name, exp, 64'(rd));
    endtask

    // Folds seen mid-cycle come from the previous edge
    task automatic push(input logic [1:0] n, input logic taken);
        result_en       = 1'b1;
        result_cond_num = n;
        result_taken    = taken;
        @(negedge clk);
        check_state(pos_m);
        @(posedge clk);
        #1;
        result_en       = 1'b0;
        result_cond_num = 2'd0;
        result_taken    = 1'b0;
        if (!frozen_m) model_push(n, taken);
    endtask

    task automatic restore_step(input logic sq, input logic rd, input hist_ckpt_t ck_sq,
                                input hist_ckpt_t ck_rd, input logic [1:0] n,
                                input logic taken);
        hist_ckpt_t win;
        logic [5:0] exp_idx;
        logic [1:0] other_n;
        logic       other_taken;
        win             = sq ? ck_sq : ck_rd;   // Squash wins
        exp_idx         = win.ghist_idx + 6'(n);
        other_n         = 2'd3 - n;   // Losing source carries a different block
        other_taken     = ~taken;
        squash          = sq;
        squash_ckpt     = ck_sq;
        squash_cond_num = sq ? n : other_n;
        squash_taken    = sq ? taken : other_taken;
        s2_redirect     = rd;
        redir_ckpt      = ck_rd;
        result_en       = 1'b1;
        result_cond_num = sq ? other_n : n;
        result_taken    = sq ? other_taken : taken;
        @(negedge clk);
        check_hex("hist_idx", 64'(exp_idx), 64'(hist_idx));
        @(posedge clk);
        #1;
        squash          = 1'b0;
        s2_redirect     = 1'b0;
        result_en       = 1'b0;
        result_cond_num = 2'd0;
        result_taken    = 1'b0;
        pos_m = int'(win.ghist_idx);
        model_push(n, taken);
        if (sq) exp_squash++;
        else if (rd) exp_redir++;
        idle_check();
    endtask

    // ********************
    // Tests
    // ********************
    task automatic random_pushes();
        logic [1:0]  n;
        logic        taken;
        logic [63:0] v;
        fold_hist_t  f;
        logic [7:0]  fa;
        for (int i = 0; i < N_PUSH; i++) begin
            n = 2'(rand_bits(2));
            if (n == 2'd3) n = 2'd2;
            taken = lfsr_bit();
            push(n, taken);
        end
        idle_check();
        v = model_ghist();
        read_check("ghist_lo", CSR_GHIST_LO, 64'(v[31:0]));
        read_check("ghist_hi", CSR_GHIST_HI, 64'(v[63:32]));
        f = model_folds();
        for (int b = 0; b < `TAGE_BANK; b++) begin
            fa = 8'(CSR_FOLD_BASE + 4 * b);   // One window per bank
            read_check($sformatf("csr_fold_idx[%0d]", b), fa + 8'(FOLD_FIELD_IDX),
                       64'(f.fold_idx[b]));
            read_check($sformatf("csr_fold_tag1[%0d]", b), fa + 8'(FOLD_FIELD_TAG1),
                       64'(f.fold_tag1[b]));
            read_check($sformatf("csr_fold_tag2[%0d]", b), fa + 8'(FOLD_FIELD_TAG2),
                       64'(f.fold_tag2[b]));
        end
    endtask

    task automatic redirect_test();
        hist_ckpt_t ck;
        ck = take_ckpt();
        push(2'd2, 1'b1);
        push(2'd1, 1'b1);
        push(2'd2, 1'b0);
        restore_step(1'b0, 1'b1, '0, ck, 2'd2, 1'b1);
    endtask

    task automatic squash_test();
        hist_ckpt_t ck_old;
        hist_ckpt_t ck_new;
        ck_old = take_ckpt();
        push(2'd2, 1'b1);
        ck_new = take_ckpt();
        push(2'd1, 1'b0);
        push(2'd2, 1'b1);
        restore_step(1'b1, 1'b1, ck_old, ck_new, 2'd1, 1'b1);
        read_check("count_redir", CSR_COUNT_REDIR, 64'(exp_redir));
        read_check("count_squash", CSR_COUNT_SQUASH, 64'(exp_squash));
    endtask

    task automatic freeze_test();
        hist_ckpt_t  ck;
        logic [31:0] rd;
        ck = take_ckpt();
        push(2'd2, 1'b0);
        push(2'd1, 1'b1);
        wb_access(1'b1, CSR_CTRL, 32'd1 << CTRL_FREEZE_BIT, rd);
        frozen_m = 1'b1;
        for (int i = 0; i < 6; i++) push(2'd1 + 2'(i % 2), 1'b1);
        restore_step(1'b1, 1'b0, ck, '0, 2'd2, 1'b0);
        read_check("count_squash", CSR_COUNT_SQUASH, 64'(exp_squash));
        wb_access(1'b1, CSR_CTRL, 32'd0, rd);
        frozen_m = 1'b0;
        push(2'd1, 1'b1);
        idle_check();
    endtask

    task automatic clear_test();
        logic [31:0] rd;
        wb_access(1'b1, CSR_CTRL, 32'd1 << CTRL_CLEAR_BIT, rd);
        @(posedge clk);   // Clear pulse takes effect here
        #1;
        for (int i = 0; i < `GHIST_SIZE; i++) hist_m[i] = 1'b0;
        pos_m      = 0;
        exp_redir  = 0;
        exp_squash = 0;
        idle_check();
        read_check("pos", CSR_POS, 64'd0);
        read_check("count_redir", CSR_COUNT_REDIR, 64'd0);
        read_check("count_squash", CSR_COUNT_SQUASH, 64'd0);
        read_check("ghist_lo", CSR_GHIST_LO, 64'd0);
        read_check("ghist_hi", CSR_GHIST_HI, 64'd0);
    endtask

    initial begin
        result_en       = 1'b0;
        result_cond_num = 2'd0;
        result_taken    = 1'b0;
        s2_redirect     = 1'b0;
        redir_ckpt      = '0;
        squash          = 1'b0;
        squash_ckpt     = '0;
        squash_cond_num = 2'd0;
        squash_taken    = 1'b0;
        wb_cyc          = 1'b0;
        wb_stb          = 1'b0;
        wb_we           = 1'b0;
        wb_adr          = 8'd0;
        wb_dat_w        = 32'd0;
        lfsr            = 16'd32608;
        pos_m           = 0;
        frozen_m        = 1'b0;
        errors          = 0;
        checks          = 0;
        exp_redir       = 0;
        exp_squash      = 0;
        for (int i = 0; i < `GHIST_SIZE; i++) hist_m[i] = 1'b0;
        wait (rst === 1'b0);
        @(posedge clk);
        #1;
        random_pushes();
        redirect_test();
        squash_test();
        freeze_test();
        clear_test();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
verilog/bp_hist_pkg.sv
verilog/bp_csr_pkg.sv
verilog/fold_history.sv
verilog/history_control.sv
verilog/hist_csr.sv
verilog/bp_history_top.sv
dv/hist_tb_clk.sv
dv/hist_properties.sv
dv/hist_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module hist_tb -o hist_tb_sim

output=$(./obj_dir/hist_tb_sim)
echo "$output"

if grep -q "=== PASS ===" <<< "$output"; then
    exit 0
fi
exit 1
